// ==== hdl/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

  // Primary opcode field in bits 31:26
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDI    = 6'h08,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_SLTIU   = 6'h0b,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_t;

  // Function field of SPECIAL instructions in bits 5:0
  typedef enum logic [5:0] {
    FUNC_SLL   = 6'h00,
    FUNC_SRL   = 6'h02,
    FUNC_SRA   = 6'h03,
    FUNC_SLLV  = 6'h04,
    FUNC_SRLV  = 6'h06,
    FUNC_SRAV  = 6'h07,
    FUNC_MFHI  = 6'h10,
    FUNC_MFLO  = 6'h12,
    FUNC_MULT  = 6'h18,
    FUNC_MULTU = 6'h19,
    FUNC_ADD   = 6'h20,
    FUNC_ADDU  = 6'h21,
    FUNC_SUB   = 6'h22,
    FUNC_SUBU  = 6'h23,
    FUNC_AND   = 6'h24,
    FUNC_OR    = 6'h25,
    FUNC_XOR   = 6'h26,
    FUNC_NOR   = 6'h27
  } func_t;

  typedef logic [15:0] imm_t;
  typedef logic [4:0]  shamt_t;

  // Lowest bit of each instruction field
  localparam int OPCODE_LSB = 26;
  localparam int RT_LSB     = 16;
  localparam int RD_LSB     = 11;
  localparam int SHAMT_LSB  = 6;
  localparam int FUNCT_LSB  = 0;
  localparam int IMM_LSB    = 0;

endpackage

`default_nettype wire

// ==== hdl/exec_types_pkg.sv ====
`default_nettype none

package exec_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [63:0] prod_t;

  // What a retiring instruction does with its result
  typedef enum logic [2:0] {
    RK_REG  = 3'd0,
    RK_ADDR = 3'd1,
    RK_HILO = 3'd2,
    RK_MFHI = 3'd3,  // lane to collector only
    RK_MFLO = 3'd4,  // lane to collector only
    RK_TRAP = 3'd5,
    RK_NONE = 3'd6
  } retire_kind_t;

  // Register stages inside one ALU lane
  localparam int LANE_LATENCY = 1;

endpackage

`default_nettype wire

// ==== hdl/issue_dispatch.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_dispatch #(
  parameter int NUM_LANES = 4
) (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     issue_i,
  input  exec_types_pkg::word_t    instr_i,
  input  exec_types_pkg::word_t    rs_val_i,
  input  exec_types_pkg::word_t    rt_val_i,
  output logic [NUM_LANES-1:0]     lane_valid_o,
  output mips_isa_pkg::opcode_t    opcode_o,
  output mips_isa_pkg::func_t      funct_o,
  output exec_types_pkg::reg_idx_t dest_o,
  output exec_types_pkg::word_t    imm_sext_o,
  output exec_types_pkg::word_t    imm_zext_o,
  output mips_isa_pkg::shamt_t     shamt_o,
  output exec_types_pkg::word_t    rs_o,
  output exec_types_pkg::word_t    rt_o
);

  localparam int IDX_W = $clog2(NUM_LANES);

  logic [IDX_W-1:0]         rr_ptr;
  mips_isa_pkg::opcode_t    opcode;
  mips_isa_pkg::func_t      funct;
  mips_isa_pkg::imm_t       imm;
  exec_types_pkg::reg_idx_t dest;

  // Field extraction from the raw instruction word
  assign opcode = mips_isa_pkg::opcode_t'(instr_i[mips_isa_pkg::OPCODE_LSB +: 6]);
  assign funct  = mips_isa_pkg::func_t'(instr_i[mips_isa_pkg::FUNCT_LSB +: 6]);
  assign imm    = instr_i[mips_isa_pkg::IMM_LSB +: 16];

  // R-type writes rd and everything else writes rt
  assign dest = (opcode == mips_isa_pkg::OP_SPECIAL) ? instr_i[mips_isa_pkg::RD_LSB +: 5]
                                                     : instr_i[mips_isa_pkg::RT_LSB +: 5];

  // Round-robin pointer and one-hot lane strobe
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rr_ptr       <= '0;
      lane_valid_o <= '0;
    end else begin
      lane_valid_o <= '0;
      if (issue_i) begin
        lane_valid_o[rr_ptr] <= 1'b1;
        rr_ptr <= (rr_ptr == IDX_W'(NUM_LANES - 1)) ? '0 : rr_ptr + 1'b1;
      end
    end
  end

  // Operands broadcast to every lane
  always_ff @(posedge clk) begin
    if (issue_i) begin
      opcode_o   <= opcode;
      funct_o    <= funct;
      dest_o     <= dest;
      imm_sext_o <= {{16{imm[15]}}, imm};
      imm_zext_o <= {16'b0, imm};
      shamt_o    <= instr_i[mips_isa_pkg::SHAMT_LSB +: 5];
      rs_o       <= rs_val_i;
      rt_o       <= rt_val_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/alu_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_lane (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         valid_i,
  input  mips_isa_pkg::opcode_t        opcode_i,
  input  mips_isa_pkg::func_t          funct_i,
  input  exec_types_pkg::reg_idx_t     dest_i,
  input  exec_types_pkg::word_t        imm_sext_i,
  input  exec_types_pkg::word_t        imm_zext_i,
  input  mips_isa_pkg::shamt_t         shamt_i,
  input  exec_types_pkg::word_t        rs_i,
  input  exec_types_pkg::word_t        rt_i,
  output logic                         valid_o,
  output exec_types_pkg::retire_kind_t kind_o,
  output exec_types_pkg::reg_idx_t     dest_o,
  output exec_types_pkg::word_t        value_o,
  output exec_types_pkg::prod_t        prod_o
);

  exec_types_pkg::retire_kind_t kind_d;
  exec_types_pkg::word_t        value_d;
  exec_types_pkg::prod_t        prod_d;
  exec_types_pkg::word_t        sum_rr;
  exec_types_pkg::word_t        diff_rr;
  exec_types_pkg::word_t        sum_ri;
  logic                         ovf_add;
  logic                         ovf_sub;
  logic                         ovf_addi;

  // Variable shifts take the low five bits of rs
  mips_isa_pkg::shamt_t         var_shamt;
  assign var_shamt = rs_i[4:0];

  assign sum_rr  = rs_i + rt_i;
  assign diff_rr = rs_i - rt_i;
  assign sum_ri  = rs_i + imm_sext_i;

  // Signed overflow when the result sign disagrees with both like-signed operands
  assign ovf_add  = (rs_i[31] == rt_i[31]) && (sum_rr[31] != rs_i[31]);
  assign ovf_sub  = (rs_i[31] != rt_i[31]) && (diff_rr[31] != rs_i[31]);
  assign ovf_addi = (rs_i[31] == imm_sext_i[31]) && (sum_ri[31] != rs_i[31]);

  always_comb begin
    kind_d  = exec_types_pkg::RK_NONE;
    value_d = '0;
    prod_d  = '0;
    case (opcode_i)
      mips_isa_pkg::OP_SPECIAL: begin
        kind_d = exec_types_pkg::RK_REG;
        case (funct_i)
          mips_isa_pkg::FUNC_SLL:  value_d = rt_i << shamt_i;
          mips_isa_pkg::FUNC_SRL:  value_d = rt_i >> shamt_i;
          mips_isa_pkg::FUNC_SRA:  value_d = exec_types_pkg::word_t'($signed(rt_i) >>> shamt_i);
          mips_isa_pkg::FUNC_SLLV: value_d = rt_i << var_shamt;
          mips_isa_pkg::FUNC_SRLV: value_d = rt_i >> var_shamt;
          mips_isa_pkg::FUNC_SRAV: value_d = exec_types_pkg::word_t'($signed(rt_i) >>> var_shamt);
          mips_isa_pkg::FUNC_ADD: begin
            value_d = sum_rr;
            if (ovf_add) begin
              kind_d = exec_types_pkg::RK_TRAP;
            end
          end
          mips_isa_pkg::FUNC_ADDU: value_d = sum_rr;
          mips_isa_pkg::FUNC_SUB: begin
            value_d = diff_rr;
            if (ovf_sub) begin
              kind_d = exec_types_pkg::RK_TRAP;
            end
          end
          mips_isa_pkg::FUNC_SUBU: value_d = diff_rr;
          mips_isa_pkg::FUNC_AND:  value_d = rs_i & rt_i;
          mips_isa_pkg::FUNC_OR:   value_d = rs_i | rt_i;
          mips_isa_pkg::FUNC_XOR:  value_d = rs_i ^ rt_i;
          mips_isa_pkg::FUNC_NOR:  value_d = ~(rs_i | rt_i);
          mips_isa_pkg::FUNC_MULT: begin
            kind_d = exec_types_pkg::RK_HILO;
            prod_d = $signed({{32{rs_i[31]}}, rs_i}) * $signed({{32{rt_i[31]}}, rt_i});
          end
          mips_isa_pkg::FUNC_MULTU: begin
            kind_d = exec_types_pkg::RK_HILO;
            prod_d = {32'b0, rs_i} * {32'b0, rt_i};
          end
          // HI/LO value is filled in by the collector
          mips_isa_pkg::FUNC_MFHI: kind_d = exec_types_pkg::RK_MFHI;
          mips_isa_pkg::FUNC_MFLO: kind_d = exec_types_pkg::RK_MFLO;
          default:                 kind_d = exec_types_pkg::RK_NONE;
        endcase
      end
      mips_isa_pkg::OP_ADDI: begin
        value_d = sum_ri;
        kind_d  = ovf_addi ? exec_types_pkg::RK_TRAP : exec_types_pkg::RK_REG;
      end
      mips_isa_pkg::OP_ADDIU: begin
        value_d = sum_ri;
        kind_d  = exec_types_pkg::RK_REG;
      end
      mips_isa_pkg::OP_SLTI: begin
        value_d = {31'b0, $signed(rs_i) < $signed(imm_sext_i)};
        kind_d  = exec_types_pkg::RK_REG;
      end
      // Unsigned compare that still uses the sign-extended immediate
      mips_isa_pkg::OP_SLTIU: begin
        value_d = {31'b0, rs_i < imm_sext_i};
        kind_d  = exec_types_pkg::RK_REG;
      end
      mips_isa_pkg::OP_ANDI: begin
        value_d = rs_i & imm_zext_i;
        kind_d  = exec_types_pkg::RK_REG;
      end
      mips_isa_pkg::OP_ORI: begin
        value_d = rs_i | imm_zext_i;
        kind_d  = exec_types_pkg::RK_REG;
      end
      mips_isa_pkg::OP_XORI: begin
        value_d = rs_i ^ imm_zext_i;
        kind_d  = exec_types_pkg::RK_REG;
      end
      mips_isa_pkg::OP_LUI: begin
        value_d = {imm_zext_i[15:0], 16'b0};
        kind_d  = exec_types_pkg::RK_REG;
      end
      mips_isa_pkg::OP_LW, mips_isa_pkg::OP_SW: begin
        value_d = sum_ri;
        kind_d  = exec_types_pkg::RK_ADDR;
      end
      default: kind_d = exec_types_pkg::RK_NONE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Result registers load only when this lane is selected
  always_ff @(posedge clk) begin
    if (valid_i) begin
      kind_o  <= kind_d;
      dest_o  <= dest_i;
      value_o <= value_d;
      prod_o  <= prod_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/retire_collect.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic [NUM_LANES-1:0]         lane_valid_i,
  input  exec_types_pkg::retire_kind_t lane_kind_i  [NUM_LANES],
  input  exec_types_pkg::reg_idx_t     lane_dest_i  [NUM_LANES],
  input  exec_types_pkg::word_t        lane_value_i [NUM_LANES],
  input  exec_types_pkg::prod_t        lane_prod_i  [NUM_LANES],
  output logic                         retire_valid_o,
  output exec_types_pkg::retire_kind_t retire_kind_o,
  output exec_types_pkg::reg_idx_t     retire_dest_o,
  output exec_types_pkg::word_t        retire_value_o,
  output exec_types_pkg::word_t        hi_o,
  output exec_types_pkg::word_t        lo_o
);

  localparam int IDX_W = $clog2(NUM_LANES);

  logic [IDX_W-1:0]             sel_idx;
  exec_types_pkg::retire_kind_t sel_kind;
  exec_types_pkg::word_t        hi_q;
  exec_types_pkg::word_t        lo_q;

  // At most one lane is valid, so a simple scan finds it
  always_comb begin
    sel_idx = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      if (lane_valid_i[k]) begin
        sel_idx = IDX_W'(k);
      end
    end
  end

  assign retire_valid_o = |lane_valid_i;
  assign sel_kind       = lane_kind_i[sel_idx];
  assign retire_dest_o  = lane_dest_i[sel_idx];

  // Moves from HI/LO retire as ordinary register writes
  always_comb begin
    retire_value_o = lane_value_i[sel_idx];
    retire_kind_o  = sel_kind;
    if (!retire_valid_o) begin
      retire_kind_o = exec_types_pkg::RK_NONE;
    end else if (sel_kind == exec_types_pkg::RK_MFHI) begin
      retire_kind_o  = exec_types_pkg::RK_REG;
      retire_value_o = hi_q;
    end else if (sel_kind == exec_types_pkg::RK_MFLO) begin
      retire_kind_o  = exec_types_pkg::RK_REG;
      retire_value_o = lo_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      hi_q <= '0;
      lo_q <= '0;
    end else if (retire_valid_o && sel_kind == exec_types_pkg::RK_HILO) begin
      {hi_q, lo_q} <= lane_prod_i[sel_idx];
    end
  end

  assign hi_o = hi_q;
  assign lo_o = lo_q;

endmodule

`default_nettype wire

// ==== hdl/exec_cluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_cluster #(
  parameter int NUM_LANES = 4
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         issue_i,
  input  exec_types_pkg::word_t        instr_i,
  input  exec_types_pkg::word_t        rs_val_i,
  input  exec_types_pkg::word_t        rt_val_i,
  output logic                         retire_valid_o,
  output exec_types_pkg::retire_kind_t retire_kind_o,
  output exec_types_pkg::reg_idx_t     retire_dest_o,
  output exec_types_pkg::word_t        retire_value_o,
  output exec_types_pkg::word_t        hi_o,
  output exec_types_pkg::word_t        lo_o
);

  // Dispatcher to lanes with the shared fields going to every lane
  logic [NUM_LANES-1:0]     lane_valid;
  mips_isa_pkg::opcode_t    lane_opcode;
  mips_isa_pkg::func_t      lane_funct;
  exec_types_pkg::reg_idx_t lane_dest;
  exec_types_pkg::word_t    lane_imm_sext;
  exec_types_pkg::word_t    lane_imm_zext;
  mips_isa_pkg::shamt_t     lane_shamt;
  exec_types_pkg::word_t    lane_rs;
  exec_types_pkg::word_t    lane_rt;

  // Lanes to collector
  logic [NUM_LANES-1:0]         out_valid;
  exec_types_pkg::retire_kind_t out_kind  [NUM_LANES];
  exec_types_pkg::reg_idx_t     out_dest  [NUM_LANES];
  exec_types_pkg::word_t        out_value [NUM_LANES];
  exec_types_pkg::prod_t        out_prod  [NUM_LANES];

  issue_dispatch #(
    .NUM_LANES(NUM_LANES)
  ) u_dispatch (
    .clk         (clk),
    .reset_i     (reset_i),
    .issue_i     (issue_i),
    .instr_i     (instr_i),
    .rs_val_i    (rs_val_i),
    .rt_val_i    (rt_val_i),
    .lane_valid_o(lane_valid),
    .opcode_o    (lane_opcode),
    .funct_o     (lane_funct),
    .dest_o      (lane_dest),
    .imm_sext_o  (lane_imm_sext),
    .imm_zext_o  (lane_imm_zext),
    .shamt_o     (lane_shamt),
    .rs_o        (lane_rs),
    .rt_o        (lane_rt)
  );

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    alu_lane u_lane (
      .clk       (clk),
      .reset_i   (reset_i),
      .valid_i   (lane_valid[k]),
      .opcode_i  (lane_opcode),
      .funct_i   (lane_funct),
      .dest_i    (lane_dest),
      .imm_sext_i(lane_imm_sext),
      .imm_zext_i(lane_imm_zext),
      .shamt_i   (lane_shamt),
      .rs_i      (lane_rs),
      .rt_i      (lane_rt),
      .valid_o   (out_valid[k]),
      .kind_o    (out_kind[k]),
      .dest_o    (out_dest[k]),
      .value_o   (out_value[k]),
      .prod_o    (out_prod[k])
    );
  end

  retire_collect #(
    .NUM_LANES(NUM_LANES)
  ) u_collect (
    .clk           (clk),
    .reset_i       (reset_i),
    .lane_valid_i  (out_valid),
    .lane_kind_i   (out_kind),
    .lane_dest_i   (out_dest),
    .lane_value_i  (out_value),
    .lane_prod_i   (out_prod),
    .retire_valid_o(retire_valid_o),
    .retire_kind_o (retire_kind_o),
    .retire_dest_o (retire_dest_o),
    .retire_value_o(retire_value_o),
    .hi_o          (hi_o),
    .lo_o          (lo_o)
  );

endmodule

`default_nettype wire

// ==== bench/exec_cluster_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_cluster_checker #(
  parameter int NUM_LANES = 4
) (
  input logic                         clk,
  input logic                         reset_i,
  input logic                         issue_i,
  input logic [NUM_LANES-1:0]         lane_valid_i,
  input logic                         retire_valid_i,
  input exec_types_pkg::retire_kind_t retire_kind_i
);

  // Inputs change just after the rising edge and are settled by the falling edge
  a_lane_onehot: assert property (@(negedge clk) disable iff (reset_i)
    $onehot0(lane_valid_i))
    else $error("more than one lane output valid: %b", lane_valid_i);

  a_retire_after_issue: assert property (@(negedge clk) disable iff (reset_i)
    issue_i |-> ##2 retire_valid_i)
    else $error("issue was not retired two cycles later");

  a_no_orphan_retire: assert property (@(negedge clk) disable iff (reset_i)
    retire_valid_i |-> $past(issue_i, 2))
    else $error("retire without a matching issue two cycles earlier");

  a_kind_resolved: assert property (@(negedge clk) disable iff (reset_i)
    retire_valid_i |-> (retire_kind_i != exec_types_pkg::RK_MFHI &&
                        retire_kind_i != exec_types_pkg::RK_MFLO))
    else $error("unresolved HI/LO move on the retire port");

endmodule

`default_nettype wire

// ==== bench/exec_cluster_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_cluster_tb;

  localparam int          NUM_LANES  = 4;
  localparam int          NUM_RANDOM = 400;
  localparam int          NUM_DIRECT = 6;
  localparam int          CLK_PERIOD = 100;
  localparam int unsigned SEED       = 32'he20fbc27;

  // Supported R-type functions and I-type opcodes
  localparam logic [17:0][5:0] FUNC_LIST = {
    mips_isa_pkg::FUNC_SLL,  mips_isa_pkg::FUNC_SRL,   mips_isa_pkg::FUNC_SRA,
    mips_isa_pkg::FUNC_SLLV, mips_isa_pkg::FUNC_SRLV,  mips_isa_pkg::FUNC_SRAV,
    mips_isa_pkg::FUNC_MFHI, mips_isa_pkg::FUNC_MFLO,  mips_isa_pkg::FUNC_MULT,
    mips_isa_pkg::FUNC_MULTU, mips_isa_pkg::FUNC_ADD,  mips_isa_pkg::FUNC_ADDU,
    mips_isa_pkg::FUNC_SUB,  mips_isa_pkg::FUNC_SUBU,  mips_isa_pkg::FUNC_AND,
    mips_isa_pkg::FUNC_OR,   mips_isa_pkg::FUNC_XOR,   mips_isa_pkg::FUNC_NOR
  };
  localparam logic [9:0][5:0] OP_LIST = {
    mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI,
    mips_isa_pkg::OP_SLTIU, mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI,
    mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI, mips_isa_pkg::OP_LW, mips_isa_pkg::OP_SW
  };

  typedef struct {
    string                        name;
    int                           cycle;
    exec_types_pkg::retire_kind_t kind;
    exec_types_pkg::reg_idx_t     dest;
    exec_types_pkg::word_t        value;
    exec_types_pkg::word_t        hi;
    exec_types_pkg::word_t        lo;
  } retire_rec_t;

  logic                         clk;
  logic                         reset_i;
  logic                         issue_i;
  exec_types_pkg::word_t        instr_i;
  exec_types_pkg::word_t        rs_val_i;
  exec_types_pkg::word_t        rt_val_i;
  logic                         retire_valid_o;
  exec_types_pkg::retire_kind_t retire_kind_o;
  exec_types_pkg::reg_idx_t     retire_dest_o;
  exec_types_pkg::word_t        retire_value_o;
  exec_types_pkg::word_t        hi_o;
  exec_types_pkg::word_t        lo_o;

  retire_rec_t           expect_q[$];
  exec_types_pkg::word_t model_hi = '0;
  exec_types_pkg::word_t model_lo = '0;
  int                    cyc = 0;
  int                    check_count = 0;
  int                    err_count = 0;
  int                    tests_run = 0;

  exec_cluster #(
    .NUM_LANES(NUM_LANES)
  ) u_dut (
    .clk           (clk),
    .reset_i       (reset_i),
    .issue_i       (issue_i),
    .instr_i       (instr_i),
    .rs_val_i      (rs_val_i),
    .rt_val_i      (rt_val_i),
    .retire_valid_o(retire_valid_o),
    .retire_kind_o (retire_kind_o),
    .retire_dest_o (retire_dest_o),
    .retire_value_o(retire_value_o),
    .hi_o          (hi_o),
    .lo_o          (lo_o)
  );

  bind exec_cluster exec_cluster_checker #(.NUM_LANES(NUM_LANES)) u_checker (
    .clk           (clk),
    .reset_i       (reset_i),
    .issue_i       (issue_i),
    .lane_valid_i  (out_valid),
    .retire_valid_i(retire_valid_o),
    .retire_kind_i (retire_kind_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic exec_types_pkg::word_t corner_word();
    case ($urandom_range(0, 7))
      0:       return 32'h7fffffff;
      1:       return 32'h80000000;
      2:       return 32'hffffffff;
      3:       return 32'h00000001;
      default: return $urandom();
    endcase
  endfunction

  function automatic mips_isa_pkg::imm_t corner_imm();
    case ($urandom_range(0, 5))
      0:       return 16'h7fff;
      1:       return 16'h8000;
      2:       return 16'hffff;
      default: return 16'($urandom());
    endcase
  endfunction

  function automatic exec_types_pkg::word_t random_instr();
    int sel;
    sel = $urandom_range(0, 27);
    if (sel < 18) begin
      return {6'h00, 5'($urandom()), 5'($urandom()), 5'($urandom()), 5'($urandom()),
              FUNC_LIST[sel]};
    end
    return {OP_LIST[sel - 18], 5'($urandom()), 5'($urandom()), corner_imm()};
  endfunction

  function automatic exec_types_pkg::word_t rtype(input logic [5:0] fn, input logic [4:0] rd);
    return {6'h00, 5'd0, 5'd0, rd, 5'd0, fn};
  endfunction

  // Exact sum out of the 32-bit signed range means overflow
  function automatic exec_types_pkg::retire_kind_t overflow_kind(input longint sum);
    if (sum > 64'sd2147483647 || sum < -64'sd2147483648) begin
      return exec_types_pkg::RK_TRAP;
    end
    return exec_types_pkg::RK_REG;
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      err_count++;
      $display("error %s %s: expected %h actual %h", test, what, expected, actual);
    end
  endtask

  task automatic model_push(input exec_types_pkg::word_t instr, input exec_types_pkg::word_t rs,
                            input exec_types_pkg::word_t rt, input string test);
    retire_rec_t           rec;
    mips_isa_pkg::opcode_t op;
    mips_isa_pkg::func_t   fn;
    logic [4:0]            sh;
    exec_types_pkg::word_t se;
    exec_types_pkg::word_t ze;
    logic [63:0]           prod;
    op        = mips_isa_pkg::opcode_t'(instr[31:26]);
    fn        = mips_isa_pkg::func_t'(instr[5:0]);
    sh        = instr[10:6];
    se        = {{16{instr[15]}}, instr[15:0]};
    ze        = {16'h0000, instr[15:0]};
    rec.cycle = cyc;
    rec.hi    = model_hi;
    rec.lo    = model_lo;
    rec.kind  = exec_types_pkg::RK_REG;
    rec.value = '0;
    if (op == mips_isa_pkg::OP_SPECIAL) begin
      rec.dest = instr[15:11];
      rec.name = {test, " ", fn.name()};
      case (fn)
        mips_isa_pkg::FUNC_SLL:  rec.value = rt << sh;
        mips_isa_pkg::FUNC_SRL:  rec.value = rt >> sh;
        mips_isa_pkg::FUNC_SRA:  rec.value = (rt >> sh) | (rt[31] ? ~(32'hffffffff >> sh) : '0);
        mips_isa_pkg::FUNC_SLLV: rec.value = rt << rs[4:0];
        mips_isa_pkg::FUNC_SRLV: rec.value = rt >> rs[4:0];
        mips_isa_pkg::FUNC_SRAV:
          rec.value = (rt >> rs[4:0]) | (rt[31] ? ~(32'hffffffff >> rs[4:0]) : '0);
        mips_isa_pkg::FUNC_MFHI: rec.value = model_hi;
        mips_isa_pkg::FUNC_MFLO: rec.value = model_lo;
        mips_isa_pkg::FUNC_MULT: begin
          rec.kind = exec_types_pkg::RK_HILO;
          prod = longint'($signed(rs)) * longint'($signed(rt));
          {model_hi, model_lo} = prod;
        end
        mips_isa_pkg::FUNC_MULTU: begin
          rec.kind = exec_types_pkg::RK_HILO;
          prod = 64'(rs) * 64'(rt);
          {model_hi, model_lo} = prod;
        end
        mips_isa_pkg::FUNC_ADD: begin
          rec.value = rs + rt;
          rec.kind  = overflow_kind(longint'($signed(rs)) + longint'($signed(rt)));
        end
        mips_isa_pkg::FUNC_ADDU: rec.value = rs + rt;
        mips_isa_pkg::FUNC_SUB: begin
          rec.value = rs - rt;
          rec.kind  = overflow_kind(longint'($signed(rs)) - longint'($signed(rt)));
        end
        mips_isa_pkg::FUNC_SUBU: rec.value = rs - rt;
        mips_isa_pkg::FUNC_AND:  rec.value = rs & rt;
        mips_isa_pkg::FUNC_OR:   rec.value = rs | rt;
        mips_isa_pkg::FUNC_XOR:  rec.value = rs ^ rt;
        mips_isa_pkg::FUNC_NOR:  rec.value = ~(rs | rt);
        default:                 rec.kind = exec_types_pkg::RK_NONE;
      endcase
    end else begin
      rec.dest = instr[20:16];
      rec.name = {test, " ", op.name()};
      case (op)
        mips_isa_pkg::OP_ADDI: begin
          rec.value = rs + se;
          rec.kind  = overflow_kind(longint'($signed(rs)) + longint'($signed(se)));
        end
        mips_isa_pkg::OP_ADDIU: rec.value = rs + se;
        mips_isa_pkg::OP_SLTI:  rec.value = (int'(rs) < int'(se)) ? 32'd1 : 32'd0;
        mips_isa_pkg::OP_SLTIU: rec.value = (rs < se) ? 32'd1 : 32'd0;
        mips_isa_pkg::OP_ANDI:  rec.value = rs & ze;
        mips_isa_pkg::OP_ORI:   rec.value = rs | ze;
        mips_isa_pkg::OP_XORI:  rec.value = rs ^ ze;
        mips_isa_pkg::OP_LUI:   rec.value = {instr[15:0], 16'h0000};
        mips_isa_pkg::OP_LW, mips_isa_pkg::OP_SW: begin
          rec.value = rs + se;
          rec.kind  = exec_types_pkg::RK_ADDR;
        end
        default: rec.kind = exec_types_pkg::RK_NONE;
      endcase
    end
    expect_q.push_back(rec);
  endtask

  task automatic issue_one(input exec_types_pkg::word_t instr, input exec_types_pkg::word_t rs,
                           input exec_types_pkg::word_t rt, input string test);
    @(posedge clk);
    #5;
    issue_i  = 1'b1;
    instr_i  = instr;
    rs_val_i = rs;
    rt_val_i = rt;
    model_push(instr, rs, rt, test);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #5;
      issue_i = 1'b0;
    end
  endtask

  task automatic drain();
    while (expect_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic report_test(input string test, input int c0, input int e0);
    tests_run++;
    $display("test %s finished: %0d checks, %0d errors", test, check_count - c0,
             err_count - e0);
  endtask

  // Every retire is matched against the oldest model record
  always @(negedge clk) begin : retire_monitor
    retire_rec_t rec;
    if (!reset_i) begin
      if (retire_valid_o && expect_q.size() == 0) begin
        err_count++;
        $display("unexpected retire with nothing in flight at cycle %0d", cyc);
      end else if (retire_valid_o) begin
        rec = expect_q.pop_front();
        check_value(rec.name, "retire cycle", 64'(rec.cycle + 2), 64'(cyc));
        check_value(rec.name, "kind", 64'(rec.kind), 64'(retire_kind_o));
        check_value(rec.name, "dest", 64'(rec.dest), 64'(retire_dest_o));
        if (rec.kind == exec_types_pkg::RK_REG || rec.kind == exec_types_pkg::RK_ADDR) begin
          check_value(rec.name, "value", 64'(rec.value), 64'(retire_value_o));
        end
        check_value(rec.name, "hi", 64'(rec.hi), 64'(hi_o));
        check_value(rec.name, "lo", 64'(rec.lo), 64'(lo_o));
      end else if (expect_q.size() != 0 && cyc > expect_q[0].cycle + 2) begin
        err_count++;
        $display("missing retire for %s issued at cycle %0d", expect_q[0].name,
                 expect_q[0].cycle);
        rec = expect_q.pop_front();
      end
    end
  end

  initial begin : watchdog
    #((NUM_RANDOM + NUM_DIRECT + 20) * 3 * CLK_PERIOD);
    $display("timeout: the run did not complete in the expected number of cycles");
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    int c0;
    int e0;
    int gap;
    void'($urandom(SEED));
    clk      = 1'b0;
    reset_i  = 1'b1;
    issue_i  = 1'b0;
    instr_i  = '0;
    rs_val_i = '0;
    rt_val_i = '0;
    repeat (5) @(posedge clk);
    #5;
    reset_i = 1'b0;

    // No retire and cleared HI/LO straight out of reset
    c0 = check_count;
    e0 = err_count;
    repeat (4) begin
      @(negedge clk);
      check_value("reset_idle", "retire_valid", 64'd0, 64'(retire_valid_o));
      check_value("reset_idle", "hi", 64'd0, 64'(hi_o));
      check_value("reset_idle", "lo", 64'd0, 64'(lo_o));
    end
    report_test("reset_idle", c0, e0);

    c0 = check_count;
    e0 = err_count;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      issue_one(random_instr(), corner_word(), corner_word(), "random_mix");
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
      idle_cycles(gap);
    end
    idle_cycles(1);
    drain();
    report_test("random_mix", c0, e0);

    // Moves right behind a product must see the new HI/LO
    c0 = check_count;
    e0 = err_count;
    issue_one(rtype(mips_isa_pkg::FUNC_MULT, 5'd1), 32'h80000000, 32'h7fffffff, "hilo_b2b");
    issue_one(rtype(mips_isa_pkg::FUNC_MFHI, 5'd2), '0, '0, "hilo_b2b");
    issue_one(rtype(mips_isa_pkg::FUNC_MFLO, 5'd3), '0, '0, "hilo_b2b");
    issue_one(rtype(mips_isa_pkg::FUNC_MULTU, 5'd4), 32'hffffffff, 32'hfffffffe, "hilo_b2b");
    issue_one(rtype(mips_isa_pkg::FUNC_MFLO, 5'd5), '0, '0, "hilo_b2b");
    issue_one(rtype(mips_isa_pkg::FUNC_MFHI, 5'd6), '0, '0, "hilo_b2b");
    idle_cycles(1);
    drain();
    check_value("hilo_b2b", "final hi", 64'(model_hi), 64'(hi_o));
    check_value("hilo_b2b", "final lo", 64'(model_lo), 64'(lo_o));
    report_test("hilo_b2b", c0, e0);

    $display("tests: %0d, checks: %0d, errors: %0d", tests_run, check_count, err_count);
    if (err_count != 0) begin
      $display("Test failures found");
    end else begin
      $display("All tests passed!");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== exec_cluster.f ====
hdl/mips_isa_pkg.sv
hdl/exec_types_pkg.sv
hdl/issue_dispatch.sv
hdl/alu_lane.sv
hdl/retire_collect.sv
hdl/exec_cluster.sv
bench/exec_cluster_checker.sv
bench/exec_cluster_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := exec_cluster_tb
FILELIST   := exec_cluster.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Test failures found

SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
